// File: common/bakeryPkg.sv
/*
 * protocol location and step command enums for the bakery lock
 * plus the default process count
 */
package bakeryPkg;

	// program locations, in bakery program order
	// L2x is the defer sampling loop, L10x the exit loop
	typedef enum logic [3:0] {
		L1,
		L2a,
		L2b,
		L2c,
		L3,
		L4,
		L5,
		L6,
		L7,
		L8,
		L9,
		L10a,
		L10b,
		L10c,
		L11
	} protoLoc;

	// one command per step, issued by the sequencer
	typedef enum logic [3:0] {
		opNone,
		opSetChoosing,
		opClearIndex,
		opSampleDefer,
		opTakeTicket,
		opStartScan,
		opNextPeer,
		opPromote,
		opDropTicket,
		opClearDefer
	} stepOp;

	// process count used when the top level is not overridden
	localparam int defaultNumProc = 3;

endpackage

// File: common/bakeryStepIf.sv
/*
 * step command bus from the sequencer to the ticket table and loop counters,
 * with the status bits returned for the current process and peer
 */
`timescale 1ns/1ps

interface bakeryStepIf import bakeryPkg::*; #(
	parameter int SelWidth = $clog2(defaultNumProc + 1)
) ();

	// stepping process, always in range
	logic [SelWidth-1:0] sel;
	// what the stepping process does this cycle
	stepOp op;
	// loop index j of the stepping process
	logic [SelWidth-1:0] peer;
	// j has run past the last process
	logic scanDone;
	// status of peer, combinational on sel and peer
	logic peerChoosing;
	logic mustWait;

	modport ctrl (
		output sel, op,
		input scanDone, peerChoosing, mustWait
	);

	// ticket storage side
	modport tbl (
		input sel, op, peer,
		output peerChoosing, mustWait
	);

	modport index (
		input sel, op,
		output peer, scanDone
	);

endinterface

// File: bakery/bakeryControl.sv
/*
 * bakery protocol sequencer, one location register per process
 * and one decoded step per clock
 */
`timescale 1ns/1ps

module bakeryControl import bakeryPkg::*; #(
	parameter int NumProc = defaultNumProc,
	parameter int SelWidth = $clog2(NumProc + 1)
) (
	input logic clock,
	input logic arstN,
	input logic [SelWidth-1:0] select,
	input logic pause,
	bakeryStepIf.ctrl step,
	output protoLoc loc [NumProc]
);

	logic [SelWidth-1:0] selIdx;
	protoLoc curLoc;
	protoLoc nextLoc;
	stepOp stepCode;

	// out of range selections step process 0
	assign selIdx = (select < NumProc) ? select : '0;
	assign step.sel = selIdx;
	assign step.op = stepCode;

	always_comb begin
		curLoc = loc[selIdx];
		nextLoc = curLoc;
		stepCode = opNone;
		case (curLoc)
			// announce that a ticket is being chosen
			L1: begin
				stepCode = opSetChoosing;
				nextLoc = L2a;
			end
			L2a: begin
				stepCode = opClearIndex;
				nextLoc = L2b;
			end
			L2b: nextLoc = step.scanDone ? L3 : L2c;
			// record which peers already hold a ticket
			L2c: begin
				stepCode = opSampleDefer;
				nextLoc = L2b;
			end
			L3: begin
				stepCode = opTakeTicket;
				nextLoc = L4;
			end
			L4: begin
				stepCode = opStartScan;
				nextLoc = L5;
			end
			L5: nextLoc = step.scanDone ? L9 : L6;
			// spin while peer is still choosing
			L6: nextLoc = step.peerChoosing ? L6 : L7;
			// spin while peer has precedence, possibly passing our priority on
			L7: begin
				stepCode = opPromote;
				nextLoc = step.mustWait ? L7 : L8;
			end
			L8: begin
				stepCode = opNextPeer;
				nextLoc = L5;
			end
			// critical section
			L9: nextLoc = pause ? L9 : L10a;
			L10a: begin
				stepCode = opDropTicket;
				nextLoc = L10b;
			end
			L10b: nextLoc = step.scanDone ? L11 : L10c;
			// withdraw from every defer relation involving us
			L10c: begin
				stepCode = opClearDefer;
				nextLoc = L10b;
			end
			L11: nextLoc = pause ? L11 : L1;
			default: nextLoc = L1;
		endcase
	end

	// only the selected process moves
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < NumProc; i++) begin
				loc[i] <= L1;
			end
		end else begin
			loc[selIdx] <= nextLoc;
		end
	end

	// a peer is only addressed while the sweep is still inside the process range
	peerInRange: assert property (@(posedge clock) disable iff (!arstN)
		(curLoc inside {L2c, L6, L7, L8, L10c}) |-> !step.scanDone);

endmodule

// File: bakery/bakeryTicketTable.sv
/*
 * ticket, choosing, defer matrix and priority storage
 * with the peer status decisions for the L6 and L7 waits
 */
`timescale 1ns/1ps

module bakeryTicketTable import bakeryPkg::*; #(
	parameter int NumProc = defaultNumProc,
	parameter int SelWidth = $clog2(NumProc + 1)
) (
	input logic clock,
	input logic arstN,
	bakeryStepIf.tbl step
);

	logic [NumProc-1:0] ticket;
	logic [NumProc-1:0] choosing;
	// defer[a][b] set means a saw b holding a ticket when a chose
	logic [NumProc-1:0] defer [NumProc];
	logic [SelWidth-1:0] pri [NumProc];

	logic peerValid;
	logic [SelWidth-1:0] peerIdx;
	logic defSelPeer;
	logic defPeerSel;
	logic promote;
	logic [NumProc-1:0] selfDefer;

	// j reaches NumProc at the end of a sweep
	assign peerValid = step.peer < NumProc;
	assign peerIdx = peerValid ? step.peer : '0;

	assign defSelPeer = defer[step.sel][peerIdx];
	assign defPeerSel = defer[peerIdx][step.sel];

	assign step.peerChoosing = peerValid && choosing[peerIdx];

	// older peer ticket, or same age and better priority
	assign step.mustWait = peerValid && ticket[peerIdx] &&
		(defSelPeer || (!defPeerSel && (pri[peerIdx] < pri[step.sel])));

	// an older peer inherits our priority when it is better than its own
	assign promote = peerValid && ticket[peerIdx] && defSelPeer && !defPeerSel &&
		(pri[step.sel] < pri[peerIdx]);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			ticket <= '0;
			choosing <= '0;
			for (int i = 0; i < NumProc; i++) begin
				defer[i] <= '0;
				pri[i] <= SelWidth'(i);
			end
		end else begin
			case (step.op)
				opSetChoosing: choosing[step.sel] <= 1'b1;
				opSampleDefer: defer[step.sel][peerIdx] <= ticket[peerIdx];
				opTakeTicket: begin
					ticket[step.sel] <= 1'b1;
					choosing[step.sel] <= 1'b0;
				end
				// own priority restored before each peer comparison
				opStartScan, opNextPeer: pri[step.sel] <= step.sel;
				opPromote: begin
					if (promote) begin
						pri[peerIdx] <= pri[step.sel];
					end
				end
				opDropTicket: ticket[step.sel] <= 1'b0;
				opClearDefer: begin
					defer[peerIdx][step.sel] <= 1'b0;
					// undo a promotion we handed out
					if (pri[peerIdx] == step.sel) begin
						pri[peerIdx] <= peerIdx;
					end
				end
				default: ;
			endcase
		end
	end

	always_comb begin
		for (int i = 0; i < NumProc; i++) begin
			selfDefer[i] = defer[i][i];
		end
	end

	// own ticket is always clear during the L2 sweep
	noSelfDefer: assert property (@(posedge clock) disable iff (!arstN)
		selfDefer == '0);

endmodule

// File: bakery/bakeryLoopIndex.sv
/*
 * per-process loop index j, swept over all process indices
 */
`timescale 1ns/1ps

module bakeryLoopIndex import bakeryPkg::*; #(
	parameter int NumProc = defaultNumProc,
	parameter int SelWidth = $clog2(NumProc + 1)
) (
	input logic clock,
	input logic arstN,
	bakeryStepIf.index step
);

	// counts 0 to NumProc inclusive
	logic [SelWidth-1:0] j [NumProc];

	assign step.peer = j[step.sel];
	assign step.scanDone = j[step.sel] >= SelWidth'(NumProc);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < NumProc; i++) begin
				j[i] <= '0;
			end
		end else begin
			case (step.op)
				// start of the defer, scan and exit sweeps
				opClearIndex, opStartScan, opDropTicket: j[step.sel] <= '0;
				// one peer handled
				opSampleDefer, opNextPeer, opClearDefer: j[step.sel] <= j[step.sel] + 1'b1;
				default: ;
			endcase
		end
	end

endmodule

// File: source/mutexMonitor.sv
/*
 * critical section owner decode and sticky mutual exclusion violation flag
 */
`timescale 1ns/1ps

module mutexMonitor import bakeryPkg::*; #(
	parameter int NumProc = defaultNumProc
) (
	input logic clock,
	input logic arstN,
	input protoLoc loc [NumProc],
	output logic [NumProc-1:0] inCritical,
	output logic mutexViolation
);

	logic manyOwners;

	always_comb begin
		for (int i = 0; i < NumProc; i++) begin
			inCritical[i] = (loc[i] == L9);
		end
	end

	// clearing the lowest set bit leaves something only when two or more are set
	assign manyOwners = (inCritical & (inCritical - 1'b1)) != '0;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			mutexViolation <= 1'b0;
		end else if (manyOwners) begin
			mutexViolation <= 1'b1;
		end
	end

	// the bakery protocol as a whole must keep the owner set at most one
	mutexHolds: assert property (@(posedge clock) disable iff (!arstN)
		!$rose(mutexViolation));

endmodule

// File: source/bakeryTop.sv
/*
 * bakery lock arbiter top, sequencer, ticket table, loop counters and monitor
 */
`timescale 1ns/1ps

module bakeryTop import bakeryPkg::*; #(
	parameter int NumProc = defaultNumProc,
	// loop counters must reach NumProc itself
	localparam int SelWidth = $clog2(NumProc + 1)
) (
	input logic clock,
	input logic arstN,
	input logic [SelWidth-1:0] select,
	input logic pause,
	output logic [NumProc-1:0] inCritical,
	output protoLoc loc [NumProc],
	output logic mutexViolation
);

	bakeryStepIf #(.SelWidth(SelWidth)) stepBus ();

	bakeryControl #(.NumProc(NumProc), .SelWidth(SelWidth)) u_bakeryControl (
		.clock(clock),
		.arstN(arstN),
		.select(select),
		.pause(pause),
		.step(stepBus.ctrl),
		.loc(loc)
	);

	bakeryTicketTable #(.NumProc(NumProc), .SelWidth(SelWidth)) u_bakeryTicketTable (
		.clock(clock),
		.arstN(arstN),
		.step(stepBus.tbl)
	);

	bakeryLoopIndex #(.NumProc(NumProc), .SelWidth(SelWidth)) u_bakeryLoopIndex (
		.clock(clock),
		.arstN(arstN),
		.step(stepBus.index)
	);

	// watches the post-step locations
	mutexMonitor #(.NumProc(NumProc)) u_mutexMonitor (
		.clock(clock),
		.arstN(arstN),
		.loc(loc),
		.inCritical(inCritical),
		.mutexViolation(mutexViolation)
	);

endmodule

// File: sim/bakeryRefModel.svh
/*
 * behavioral bakery lock model, reset and one step per call,
 * plus the expected owner vector
 */
`ifndef BAKERY_REF_MODEL_SVH
`define BAKERY_REF_MODEL_SVH

// model state, one entry per process
protoLoc mLoc [NumProc];
bit mTicket [NumProc];
bit mChoosing [NumProc];
// mDefer[a][b] set when a saw b holding a ticket while choosing
bit mDefer [NumProc][NumProc];
int mPri [NumProc];
int mJ [NumProc];
bit mViol;

function automatic void resetModel();
	for (int i = 0; i < NumProc; i++) begin
		mLoc[i] = L1;
		mTicket[i] = 1'b0;
		mChoosing[i] = 1'b0;
		mPri[i] = i;
		mJ[i] = 0;
		for (int k = 0; k < NumProc; k++) begin
			mDefer[i][k] = 1'b0;
		end
	end
	mViol = 1'b0;
endfunction

function automatic void refStep(input logic [SelWidth-1:0] selIn, input logic pauseIn);
	int s;
	int j;
	int p;
	int owners;
	bit hasPeer;
	bit older;
	bit waitPeer;
	// monitor sees the locations from before this step
	owners = 0;
	for (int i = 0; i < NumProc; i++) begin
		owners += (mLoc[i] == L9);
	end
	if (owners > 1) begin
		mViol = 1'b1;
	end
	s = (selIn < NumProc) ? selIn : 0;
	j = mJ[s];
	hasPeer = j < NumProc;
	p = hasPeer ? j : 0;
	// peer chose first and we have not been seen by it
	older = hasPeer && mTicket[p] && mDefer[s][p] && !mDefer[p][s];
	waitPeer = hasPeer && mTicket[p] &&
		(mDefer[s][p] || (!mDefer[p][s] && mPri[p] < mPri[s]));
	case (mLoc[s])
		L1: begin
			mChoosing[s] = 1'b1;
			mLoc[s] = L2a;
		end
		L2a: begin
			mJ[s] = 0;
			mLoc[s] = L2b;
		end
		L2b: mLoc[s] = hasPeer ? L2c : L3;
		L2c: begin
			mDefer[s][p] = mTicket[p];
			mJ[s] = j + 1;
			mLoc[s] = L2b;
		end
		L3: begin
			mTicket[s] = 1'b1;
			mChoosing[s] = 1'b0;
			mLoc[s] = L4;
		end
		L4: begin
			mJ[s] = 0;
			mPri[s] = s;
			mLoc[s] = L5;
		end
		L5: mLoc[s] = hasPeer ? L6 : L9;
		L6: mLoc[s] = (hasPeer && mChoosing[p]) ? L6 : L7;
		// older peer inherits a better priority while we wait on it
		L7: begin
			if (older && mPri[s] < mPri[p]) begin
				mPri[p] = mPri[s];
			end
			mLoc[s] = waitPeer ? L7 : L8;
		end
		L8: begin
			mJ[s] = j + 1;
			mPri[s] = s;
			mLoc[s] = L5;
		end
		L9: mLoc[s] = pauseIn ? L9 : L10a;
		L10a: begin
			mTicket[s] = 1'b0;
			mJ[s] = 0;
			mLoc[s] = L10b;
		end
		L10b: mLoc[s] = hasPeer ? L10c : L11;
		L10c: begin
			mDefer[p][s] = 1'b0;
			if (mPri[p] == s) begin
				mPri[p] = p;
			end
			mJ[s] = j + 1;
			mLoc[s] = L10b;
		end
		L11: mLoc[s] = pauseIn ? L11 : L1;
		default: mLoc[s] = L1;
	endcase
endfunction

function automatic logic [NumProc-1:0] expectedOwners();
	logic [NumProc-1:0] owners;
	for (int i = 0; i < NumProc; i++) begin
		owners[i] = (mLoc[i] == L9);
	end
	return owners;
endfunction

`endif

// File: sim/bakeryTb.sv
/*
 * bakery lock testbench, directed and random stepping
 * checked every cycle against the reference model
 */
`timescale 1ns/1ps

module bakeryTb import bakeryPkg::*; ();

	localparam int NumProc = defaultNumProc;
	localparam int SelWidth = $clog2(NumProc + 1);

	logic clock;
	logic arstN;
	logic [SelWidth-1:0] select;
	logic pause;
	logic [NumProc-1:0] inCritical;
	protoLoc loc [NumProc];
	logic mutexViolation;
	integer seed;

	`include "bakeryRefModel.svh"

	bakeryTop #(.NumProc(NumProc)) u_bakeryTop (
		.clock(clock),
		.arstN(arstN),
		.select(select),
		.pause(pause),
		.inCritical(inCritical),
		.loc(loc),
		.mutexViolation(mutexViolation)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#2 clock = ~clock;
		end
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkValue(input logic [31:0] got, input logic [31:0] want,
		input string what);
		if (got !== want) begin
			failRun($sformatf("MISMATCH at %0t ns: %s is %0d, expected %0d",
				$time, what, got, want));
		end
	endtask

	// model steps on the same edge and with the same inputs as the DUT
	always @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			resetModel();
		end else begin
			refStep(select, pause);
		end
	end

	// compare on the falling edge, half a cycle after each step
	always @(negedge clock) begin
		if (arstN === 1'b1) begin
			for (int i = 0; i < NumProc; i++) begin
				checkValue(loc[i], mLoc[i], $sformatf("loc[%0d]", i));
			end
			checkValue(inCritical, expectedOwners(), "inCritical");
			checkValue(mutexViolation, mViol, "mutexViolation");
			checkValue($countones(inCritical) <= 1, 1, "at most one owner");
		end
	end

	// new inputs count from the next edge, this edge's step is settled by the falling edge
	task automatic driveStep(input int s, input logic p);
		@(posedge clock);
		select <= SelWidth'(s);
		pause <= p;
		@(negedge clock);
	endtask

	// firstSel is the process stepped on the first edge after release
	task automatic applyReset(input int firstSel);
		@(posedge clock);
		arstN <= 1'b0;
		pause <= 1'b0;
		repeat (2) @(posedge clock);
		arstN <= 1'b1;
		select <= SelWidth'(firstSel);
		@(negedge clock);
		for (int i = 0; i < NumProc; i++) begin
			checkValue(loc[i], L1, $sformatf("loc[%0d] after reset", i));
		end
		checkValue(inCritical, 0, "inCritical after reset");
		checkValue(mutexViolation, 0, "mutexViolation after reset");
	endtask

	initial begin
		integer r;
		int steps;
		int rr;
		logic sawCritical;
		logic [NumProc-1:0] seen;
		arstN = 1'b0;
		select = '0;
		pause = 1'b0;
		seed = 32'h6c5296cd;

		// process 1 alone walks the whole program
		applyReset(1);
		steps = 0;
		sawCritical = 1'b0;
		while (loc[1] != L11) begin
			if (steps == 200) begin
				failRun("timeout: process 1 alone never reached L11");
			end
			driveStep(1, 1'b0);
			sawCritical |= inCritical[1];
			steps++;
		end
		checkValue(sawCritical, 1, "process 1 passed through L9");

		// out of range selections move process 0
		for (int v = NumProc; v < (1 << SelWidth); v++) begin
			repeat (4) driveStep(v, 1'b0);
		end

		// lockstep round robin gives every ticket the same age
		applyReset(0);
		steps = 0;
		rr = 1;
		while (inCritical == '0) begin
			if (steps == 500) begin
				failRun("timeout: no process entered L9 in round robin");
			end
			driveStep(rr, 1'b0);
			rr = (rr + 1) % NumProc;
			steps++;
		end
		checkValue(inCritical, 1, "lowest index enters L9 first");

		// owner held by pause, the rest spin in the scan
		for (int n = 0; n < 40; n++) begin
			driveStep(rr, 1'b1);
			rr = (rr + 1) % NumProc;
			checkValue(inCritical, 1, "owner held in L9");
			for (int i = 1; i < NumProc; i++) begin
				checkValue(loc[i] >= L5 && loc[i] <= L8, 1,
					$sformatf("process %0d waiting in the scan", i));
			end
		end

		// released, everyone gets a turn
		steps = 0;
		seen = inCritical;
		while (seen != '1) begin
			if (steps == 2000) begin
				failRun("timeout: not every process reached L9 after release");
			end
			driveStep(rr, 1'b0);
			rr = (rr + 1) % NumProc;
			seen |= inCritical;
			steps++;
		end

		// long random interleaving, pause about half the time
		for (int n = 0; n < 4000; n++) begin
			r = $random(seed);
			driveStep(r, r[8]);
		end
		@(negedge clock);
		checkValue(mutexViolation, 0, "mutexViolation after random run");

		$display("TEST PASS");
		$finish;
	end

endmodule

// File: all.f
+incdir+sim
common/bakeryPkg.sv
common/bakeryStepIf.sv
bakery/bakeryControl.sv
bakery/bakeryTicketTable.sv
bakery/bakeryLoopIndex.sv
source/mutexMonitor.sv
source/bakeryTop.sv
sim/bakeryTb.sv
